// File: logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [4:0] reg_idx_t;

    // major opcodes of the kept instruction set
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        PASS_B,  // lui
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } alu_op_e;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_REL,
        DECODE,
        EXECUTE,
        HALT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        NONE,
        EBREAK,
        ILLEGAL
    } halt_cause_e;

endpackage

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] imem_data,
    input  logic        inst_capture,
    input  logic        dec_en,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output reg_idx_t    rd,
    output logic [31:0] imm,
    output alu_op_e     alu_op,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        gpr_we,
    output logic        is_branch,
    output logic        is_jal,
    output logic        is_jalr,
    output logic        is_ebreak,
    output logic        illegal
);

    logic [31:0] ir;  // instruction register
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    alu_op_e     d_alu_op;
    logic [31:0] d_imm;
    logic        d_src1_is_pc;
    logic        d_src2_is_imm;
    logic        d_gpr_we;
    logic        d_is_branch;
    logic        d_is_jal;
    logic        d_is_jalr;
    logic        d_is_ebreak;
    logic        d_illegal;

    // funct3 to alu operation, alt picks sub / sra
    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        d_alu_op      = ADD;
        d_imm         = imm_i;
        d_src1_is_pc  = 1'b0;
        d_src2_is_imm = 1'b0;
        d_gpr_we      = 1'b0;
        d_is_branch   = 1'b0;
        d_is_jal      = 1'b0;
        d_is_jalr     = 1'b0;
        d_is_ebreak   = 1'b0;
        d_illegal     = 1'b0;
        case (opcode)
            OP_REG: begin
                d_alu_op  = f3_to_op(funct3, funct7[5]);
                d_gpr_we  = 1'b1;
                d_illegal = !(funct7 == 7'h00 ||
                              (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)));
            end
            OP_IMM: begin
                d_alu_op      = f3_to_op(funct3, funct3 == 3'd5 && funct7[5]);
                d_src2_is_imm = 1'b1;
                d_gpr_we      = 1'b1;
                d_illegal     = (funct3 == 3'd1 && funct7 != 7'h00) ||
                                (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
            end
            OP_LUI: begin
                d_alu_op      = PASS_B;
                d_imm         = imm_u;
                d_src2_is_imm = 1'b1;
                d_gpr_we      = 1'b1;
            end
            OP_AUIPC: begin
                d_imm         = imm_u;
                d_src1_is_pc  = 1'b1;
                d_src2_is_imm = 1'b1;
                d_gpr_we      = 1'b1;
            end
            OP_BRANCH: begin
                d_imm       = imm_b;
                d_is_branch = 1'b1;
                case (funct3)
                    3'd0:    d_alu_op = BEQ;
                    3'd1:    d_alu_op = BNE;
                    3'd4:    d_alu_op = BLT;
                    3'd5:    d_alu_op = BGE;
                    3'd6:    d_alu_op = BLTU;
                    3'd7:    d_alu_op = BGEU;
                    default: d_illegal = 1'b1;
                endcase
            end
            OP_JAL: begin
                d_imm         = imm_j;  // alu forms pc + imm target
                d_src1_is_pc  = 1'b1;
                d_src2_is_imm = 1'b1;
                d_gpr_we      = 1'b1;
                d_is_jal      = 1'b1;
            end
            OP_JALR: begin
                d_src2_is_imm = 1'b1;
                d_gpr_we      = 1'b1;
                d_is_jalr     = 1'b1;
                d_illegal     = funct3 != 3'd0;
            end
            OP_SYSTEM: begin
                d_is_ebreak = ir == 32'h0010_0073;
                d_illegal   = ir != 32'h0010_0073;  // ecall, csr, mret
            end
            default: d_illegal = 1'b1;  // loads, stores, fence
        endcase
    end

    always_ff @(posedge clk) begin
        if (inst_capture) begin
            ir <= imem_data;
        end
        if (dec_en) begin
            rs1 <= ir[19:15];
            rs2 <= ir[24:20];
            rd  <= ir[11:7];
            imm <= d_imm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_op      <= ADD;
            src1_is_pc  <= 1'b0;
            src2_is_imm <= 1'b0;
            gpr_we      <= 1'b0;
            is_branch   <= 1'b0;
            is_jal      <= 1'b0;
            is_jalr     <= 1'b0;
            is_ebreak   <= 1'b0;
            illegal     <= 1'b0;
        end else if (dec_en) begin
            alu_op      <= d_alu_op;
            src1_is_pc  <= d_src1_is_pc;
            src2_is_imm <= d_src2_is_imm;
            gpr_we      <= d_gpr_we;
            is_branch   <= d_is_branch;
            is_jal      <= d_is_jal;
            is_jalr     <= d_is_jalr;
            is_ebreak   <= d_is_ebreak;
            illegal     <= d_illegal;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module core_ctrl_fsm import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        imem_ack,
    input  logic        is_ebreak,
    input  logic        illegal,
    output logic        imem_req,
    output logic        inst_capture,
    output logic        dec_en,
    output logic        exec_en,
    output logic        halted,
    output halt_cause_e halt_cause
);

    ctrl_state_e state;
    logic        stop;

    assign stop         = is_ebreak || illegal;
    assign inst_capture = state == FETCH_REQ && imem_req && imem_ack;
    assign dec_en       = state == DECODE;
    assign exec_en      = state == EXECUTE && !stop;
    assign halted       = state == HALT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FETCH_REQ;
            imem_req   <= 1'b0;
            halt_cause <= NONE;
        end else begin
            case (state)
                FETCH_REQ: begin
                    if (inst_capture) begin
                        imem_req <= 1'b0;  // instruction taken
                        state    <= FETCH_REL;
                    end else begin
                        imem_req <= 1'b1;
                    end
                end
                FETCH_REL: begin
                    if (!imem_ack) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    if (stop) begin
                        state      <= HALT;
                        halt_cause <= illegal ? ILLEGAL : EBREAK;
                    end else begin
                        state <= FETCH_REQ;
                    end
                end
                default: state <= HALT;  // left only by reset
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/retire_counter.sv
`timescale 1ns/1ns
`default_nettype none

module retire_counter #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exec_en,
    output logic [CNT_WIDTH-1:0] retired
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired <= '0;
        end else if (exec_en && retired != {CNT_WIDTH{1'b1}}) begin
            retired <= retired + 1'b1;  // sticks at max
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_idx_t    rs1,
    input  reg_idx_t    rs2,
    input  reg_idx_t    rd,
    input  logic        gpr_we,
    input  logic        exec_en,
    input  logic [31:0] wb_data,
    input  reg_idx_t    dbg_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] dbg_data
);

    logic [31:0] regs [1:31];  // no storage for x0

    function automatic logic [31:0] read_port(input reg_idx_t idx);
        return (idx == '0) ? 32'h0 : regs[idx];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);
    assign dbg_data = read_port(dbg_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (exec_en && gpr_we && rd != '0) begin
            regs[rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit import rv_core_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        exec_en,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] imm,
    input  alu_op_e     alu_op,
    input  logic        src1_is_pc,
    input  logic        src2_is_imm,
    input  logic        is_branch,
    input  logic        is_jal,
    input  logic        is_jalr,
    output logic [31:0] pc,
    output logic [31:0] wb_data
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        take;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;

    assign op_a     = src1_is_pc ? pc : rs1_data;
    assign op_b     = src2_is_imm ? imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        alu_res = op_a + op_b;
        take    = 1'b0;
        case (alu_op)
            SUB:    alu_res = op_a - op_b;
            SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:   alu_res = {31'b0, op_a < op_b};
            AND:    alu_res = op_a & op_b;
            OR:     alu_res = op_a | op_b;
            XOR:    alu_res = op_a ^ op_b;
            SLL:    alu_res = op_a << op_b[4:0];
            SRL:    alu_res = op_a >> op_b[4:0];
            SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            PASS_B: alu_res = op_b;
            BEQ:    take = rs1_data == rs2_data;
            BNE:    take = rs1_data != rs2_data;
            BLT:    take = $signed(rs1_data) < $signed(rs2_data);
            BGE:    take = $signed(rs1_data) >= $signed(rs2_data);
            BLTU:   take = rs1_data < rs2_data;
            BGEU:   take = rs1_data >= rs2_data;
            default: ;
        endcase
    end

    assign wb_data = (is_jal || is_jalr) ? pc_plus4 : alu_res;

    always_comb begin
        if (is_branch && take) begin
            next_pc = pc + imm;
        end else if (is_jal || is_jalr) begin
            next_pc = {alu_res[31:1], 1'b0};  // alu holds the jump target
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (exec_en) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
    parameter logic [31:0] RESET_PC  = 32'h0,
    parameter int          CNT_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 imem_req,
    output logic [31:0]          imem_addr,
    input  logic                 imem_ack,
    input  logic [31:0]          imem_data,
    output logic                 halted,
    output halt_cause_e          halt_cause,
    output logic [CNT_WIDTH-1:0] retired,
    input  reg_idx_t             dbg_addr,
    output logic [31:0]          dbg_data
);

    logic        inst_capture;
    logic        dec_en;
    logic        exec_en;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        gpr_we;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        is_ebreak;
    logic        illegal;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] wb_data;

    core_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .imem_ack     (imem_ack),
        .is_ebreak    (is_ebreak),
        .illegal      (illegal),
        .imem_req     (imem_req),
        .inst_capture (inst_capture),
        .dec_en       (dec_en),
        .exec_en      (exec_en),
        .halted       (halted),
        .halt_cause   (halt_cause)
    );

    inst_decoder u_dec (
        .clk          (clk),
        .rst          (rst),
        .imem_data    (imem_data),
        .inst_capture (inst_capture),
        .dec_en       (dec_en),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .alu_op       (alu_op),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .gpr_we       (gpr_we),
        .is_branch    (is_branch),
        .is_jal       (is_jal),
        .is_jalr      (is_jalr),
        .is_ebreak    (is_ebreak),
        .illegal      (illegal)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .gpr_we   (gpr_we),
        .exec_en  (exec_en),
        .wb_data  (wb_data),
        .dbg_addr (dbg_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

    exec_unit #(
        .RESET_PC (RESET_PC)
    ) u_exec (
        .clk         (clk),
        .rst         (rst),
        .exec_en     (exec_en),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .pc          (imem_addr),  // fetch address is the pc
        .wb_data     (wb_data)
    );

    retire_counter #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_retire (
        .clk     (clk),
        .rst     (rst),
        .exec_en (exec_en),
        .retired (retired)
    );

endmodule

`default_nettype wire

// File: verification/rv_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker import rv_core_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        imem_req,
    input logic        imem_ack,
    input logic        exec_en,
    input ctrl_state_e state
);

    int fail_count = 0;

    // request held until the ack arrives
    req_held: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> imem_req)
        else begin
            $error("imem_req dropped while imem_ack low");
            fail_count++;
        end

    // no new request before the previous ack is released
    req_wait: assert property (@(posedge clk) disable iff (rst)
        !imem_req && imem_ack |=> !imem_req)
        else begin
            $error("imem_req raised while imem_ack high");
            fail_count++;
        end

    // halt is sticky, no further fetch or retire
    halt_hold: assert property (@(posedge clk) disable iff (rst)
        state == HALT |=> state == HALT && !imem_req && !exec_en)
        else begin
            $error("core left HALT, fetched or retired while halted");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: verification/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb import rv_core_pkg::*; #(
    parameter logic [31:0] RESET_PC  = 32'h0000_0100,
    parameter int          CNT_WIDTH = 16
) ();

    localparam int          HALT_TIMEOUT = 5000;
    localparam logic [6:0]  OP_LOAD      = 7'b0000011;
    localparam logic [31:0] EBREAK_WORD  = 32'h0010_0073;
    localparam logic [31:0] MARKER       = {12'h0ad, 5'd0, 3'd0, 5'd31, OP_IMM};  // addi x31

    logic                 clk;
    logic                 rst;
    logic                 imem_req;
    logic [31:0]          imem_addr;
    logic                 imem_ack;
    logic [31:0]          imem_data;
    logic                 halted;
    halt_cause_e          halt_cause;
    logic [CNT_WIDTH-1:0] retired;
    reg_idx_t             dbg_addr;
    logic [31:0]          dbg_data;

    logic [31:0]          mem [0:255];
    logic [7:0]           load_idx;
    logic [31:0]          ref_regs [0:31];
    logic [31:0]          ref_pc;
    logic [CNT_WIDTH-1:0] ref_count;
    logic                 random_delays;
    integer               seed;
    int                   ack_delay;
    int                   wait_cnt;
    int                   mismatch_count;
    int                   timeout_count;
    int                   total_errors;

    rv_core_top #(
        .RESET_PC  (RESET_PC),
        .CNT_WIDTH (CNT_WIDTH)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .halted     (halted),
        .halt_cause (halt_cause),
        .retired    (retired),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data)
    );

    bind core_ctrl_fsm rv_core_checker chk0 (
        .clk      (clk),
        .rst      (rst),
        .imem_req (imem_req),
        .imem_ack (imem_ack),
        .exec_en  (exec_en),
        .state    (state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction memory side of the four-phase handshake
    initial begin
        imem_ack  = 1'b0;
        imem_data = 32'h0;
        ack_delay = 0;
        wait_cnt  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (imem_req && !imem_ack) begin
                if (wait_cnt >= ack_delay) begin
                    imem_data = mem[imem_addr[9:2]];
                    imem_ack  = 1'b1;
                    wait_cnt  = 0;
                end else begin
                    wait_cnt++;
                end
            end else if (!imem_req && imem_ack) begin
                imem_ack  = 1'b0;
                ack_delay = random_delays ? int'($unsigned($random(seed)) % 6) : 0;
            end
        end
    end

    function automatic logic [31:0] reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                             input reg_idx_t rd, input reg_idx_t rs1,
                                             input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] imm_inst(input logic [6:0] op, input logic [2:0] f3,
                                             input reg_idx_t rd, input reg_idx_t rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] upper_inst(input logic [6:0] op, input reg_idx_t rd,
                                               input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input reg_idx_t rs1,
                                                input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_inst(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // integer ops by funct3, alt selects sub and sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // architectural model, runs until a stop instruction
    task automatic model_run();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [31:0] imm_i;
        logic        write_rd;
        logic        done;
        int          steps;
        int          r;
        for (r = 0; r < 32; r++) begin
            ref_regs[r] = 32'h0;
        end
        ref_pc    = RESET_PC;
        ref_count = '0;
        done      = 1'b0;
        steps     = 0;
        while (!done && steps < 500) begin
            ins      = mem[ref_pc[9:2]];
            a        = ref_regs[ins[19:15]];
            imm_i    = {{20{ins[31]}}, ins[31:20]};
            nxt      = ref_pc + 32'd4;
            res      = 32'h0;
            write_rd = 1'b1;
            case (ins[6:0])
                OP_REG:    res = alu_ref(ins[14:12], ins[30], a, ref_regs[ins[24:20]]);
                OP_IMM:    res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
                OP_LUI:    res = {ins[31:12], 12'h0};
                OP_AUIPC:  res = ref_pc + {ins[31:12], 12'h0};
                OP_BRANCH: begin
                    write_rd = 1'b0;
                    if (branch_ref(ins[14:12], a, ref_regs[ins[24:20]])) begin
                        nxt = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                OP_JAL: begin
                    res = nxt;
                    nxt = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OP_JALR: begin
                    res = nxt;
                    nxt = (a + imm_i) & ~32'h1;
                end
                default: done = 1'b1;  // ebreak or unsupported
            endcase
            if (!done) begin
                if (write_rd) begin
                    ref_regs[ins[11:7]] = res;
                end
                ref_regs[0] = 32'h0;
                ref_pc      = nxt;
                ref_count   = ref_count + 1'b1;
            end
            steps++;
        end
    endtask

    task automatic clear_program();
        int i;
        for (i = 0; i < 256; i++) begin
            mem[i] = {i[24:0], OP_LOAD};  // stray fetch halts as illegal
        end
        load_idx = RESET_PC[9:2];
    endtask

    task automatic emit(input logic [31:0] word);
        mem[load_idx] = word;
        load_idx      = load_idx + 8'd1;
    endtask

    // taken branch over a marker, then a not-taken one into an increment of x10
    task automatic branch_pair(input logic [2:0] f3, input reg_idx_t t1, input reg_idx_t t2,
                               input reg_idx_t n1, input reg_idx_t n2);
        emit(branch_inst(f3, t1, t2, 13'd8));
        emit(MARKER);
        emit(branch_inst(f3, n1, n2, 13'd8));
        emit(imm_inst(OP_IMM, 3'd0, 5'd10, 5'd10, 12'h001));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_WIDTH-1:0] exp,
                               input logic [CNT_WIDTH-1:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s retired: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input halt_cause_e exp,
                               input halt_cause_e act);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s halt_cause: expected %s, actual %s", name, exp.name(),
                     act.name());
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic wait_halted(input string name, output logic ok);
        int n;
        n = 0;
        while (!halted && n < HALT_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = halted;
        if (!ok) begin
            timeout_count++;
            $display("ERROR %s: core did not halt within %0d cycles", name, HALT_TIMEOUT);
        end
    endtask

    task automatic read_reg(input reg_idx_t idx, output logic [31:0] val);
        @(posedge clk);
        #1;
        dbg_addr = idx;
        @(negedge clk);
        val = dbg_data;
    endtask

    task automatic run_program(input string name, input halt_cause_e exp_cause);
        logic        ok;
        logic [31:0] val;
        int          i;
        model_run();
        reset_core();
        wait_halted(name, ok);
        if (ok) begin
            check_cause(name, exp_cause, halt_cause);
            check_word({name, " pc"}, ref_pc, imem_addr);
            check_count(name, ref_count, retired);
            for (i = 0; i < 32; i++) begin
                read_reg(reg_idx_t'(i), val);
                check_word($sformatf("%s x%0d", name, i), ref_regs[i], val);
            end
        end
    endtask

    task automatic alu_program_test(input string name);
        clear_program();
        emit(upper_inst(OP_LUI, 5'd1, 20'h12345));
        emit(imm_inst(OP_IMM, 3'd0, 5'd1, 5'd1, 12'h678));
        emit(imm_inst(OP_IMM, 3'd0, 5'd2, 5'd0, 12'hffb));  // -5
        emit(imm_inst(OP_IMM, 3'd0, 5'd3, 5'd0, 12'h003));
        emit(reg_inst(7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
        emit(reg_inst(7'h20, 3'd0, 5'd5, 5'd2, 5'd1));      // sub
        emit(reg_inst(7'h00, 3'd7, 5'd6, 5'd1, 5'd2));
        emit(reg_inst(7'h00, 3'd6, 5'd7, 5'd1, 5'd3));
        emit(reg_inst(7'h00, 3'd4, 5'd8, 5'd1, 5'd2));
        emit(reg_inst(7'h00, 3'd2, 5'd9, 5'd2, 5'd3));
        emit(reg_inst(7'h00, 3'd3, 5'd10, 5'd2, 5'd3));
        emit(reg_inst(7'h00, 3'd1, 5'd11, 5'd1, 5'd3));
        emit(reg_inst(7'h00, 3'd5, 5'd12, 5'd2, 5'd3));
        emit(reg_inst(7'h20, 3'd5, 5'd13, 5'd2, 5'd3));     // sra
        emit(imm_inst(OP_IMM, 3'd2, 5'd14, 5'd2, 12'h000));
        emit(imm_inst(OP_IMM, 3'd3, 5'd15, 5'd3, 12'hfff));
        emit(imm_inst(OP_IMM, 3'd4, 5'd16, 5'd1, 12'h0f0));
        emit(imm_inst(OP_IMM, 3'd6, 5'd17, 5'd3, 12'h700));
        emit(imm_inst(OP_IMM, 3'd7, 5'd18, 5'd1, 12'hff0));
        emit(imm_inst(OP_IMM, 3'd1, 5'd19, 5'd1, 12'h004));
        emit(imm_inst(OP_IMM, 3'd5, 5'd20, 5'd2, 12'h01c));
        emit(imm_inst(OP_IMM, 3'd5, 5'd21, 5'd2, 12'h402)); // srai
        emit(EBREAK_WORD);
        run_program(name, EBREAK);
    endtask

    task automatic branch_jump_test();
        logic [31:0] val;
        clear_program();
        emit(imm_inst(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h005));
        emit(imm_inst(OP_IMM, 3'd0, 5'd2, 5'd0, 12'hffd));  // -3
        branch_pair(3'd0, 5'd1, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd1, 5'd1, 5'd2, 5'd1, 5'd1);
        branch_pair(3'd4, 5'd2, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd5, 5'd1, 5'd2, 5'd2, 5'd1);
        branch_pair(3'd6, 5'd1, 5'd2, 5'd2, 5'd1);
        branch_pair(3'd7, 5'd2, 5'd1, 5'd1, 5'd2);
        emit(jal_inst(5'd5, 21'd8));
        emit(MARKER);
        emit(upper_inst(OP_AUIPC, 5'd6, 20'h0));
        emit(imm_inst(OP_JALR, 3'd0, 5'd7, 5'd6, 12'd17));  // odd target
        emit(MARKER);
        emit(MARKER);
        emit(EBREAK_WORD);
        run_program("branch_jump", EBREAK);
        read_reg(5'd31, val);
        check_word("branch_jump marker x31", 32'h0, val);
        read_reg(5'd10, val);
        check_word("branch_jump fallthrough x10", 32'd6, val);
        read_reg(5'd7, val);
        check_word("branch_jump jalr link", RESET_PC + 32'd120, val);
        check_word("branch_jump halt pc", RESET_PC + 32'd128, imem_addr);
    endtask

    task automatic x0_auipc_test();
        logic [31:0] val;
        clear_program();
        emit(imm_inst(OP_IMM, 3'd0, 5'd0, 5'd0, 12'h037));
        emit(upper_inst(OP_LUI, 5'd0, 20'habcde));
        emit(imm_inst(OP_IMM, 3'd0, 5'd4, 5'd0, 12'h007));
        emit(reg_inst(7'h00, 3'd0, 5'd0, 5'd4, 5'd4));
        emit(reg_inst(7'h00, 3'd0, 5'd1, 5'd0, 5'd4));
        emit(upper_inst(OP_AUIPC, 5'd2, 20'h00000));
        emit(upper_inst(OP_AUIPC, 5'd3, 20'h00010));
        emit(EBREAK_WORD);
        run_program("x0_auipc", EBREAK);
        read_reg(5'd0, val);
        check_word("x0_auipc x0", 32'h0, val);
        read_reg(5'd1, val);
        check_word("x0_auipc x1", 32'd7, val);
        read_reg(5'd2, val);
        check_word("x0_auipc x2", RESET_PC + 32'd20, val);
        read_reg(5'd3, val);
        check_word("x0_auipc x3", RESET_PC + 32'd24 + 32'h0001_0000, val);
    endtask

    task automatic illegal_inst_test();
        clear_program();
        emit(imm_inst(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h009));
        emit(imm_inst(OP_IMM, 3'd0, 5'd2, 5'd1, 12'h001));
        emit(imm_inst(OP_LOAD, 3'd2, 5'd3, 5'd1, 12'h000));  // lw
        emit(imm_inst(OP_IMM, 3'd0, 5'd4, 5'd0, 12'h001));
        emit(EBREAK_WORD);
        run_program("illegal_inst", ILLEGAL);
        check_word("illegal_inst halt pc", RESET_PC + 32'd8, imem_addr);
        check_count("illegal_inst", CNT_WIDTH'(2), retired);
    endtask

    initial begin
        rst            = 1'b1;
        dbg_addr       = '0;
        random_delays  = 1'b0;
        seed           = 32'h26cc;
        mismatch_count = 0;
        timeout_count  = 0;
        alu_program_test("alu_program");
        branch_jump_test();
        x0_auipc_test();
        illegal_inst_test();
        random_delays = 1'b1;
        alu_program_test("random_delays");
        total_errors = mismatch_count + timeout_count + dut0.u_ctrl.chk0.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, dut0.u_ctrl.chk0.fail_count);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/rv_core_pkg.sv
logic/inst_decoder.sv
logic/core_ctrl_fsm.sv
logic/retire_counter.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/rv_core_top.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
